/* logic/line_geom_pkg.sv */
/*
 cache line geometry and word-level types shared by the ICB to AXI bridge
 import into the module body, use scoped names in port lists
*/
package line_geom_pkg;

	localparam int LINE_WORDS = 8; // words per cache line (1, 2, 4, 8 or 16)

	// data and address vectors on the ICB side
	typedef logic [31:0] word_t; // one data word
	typedef logic [31:0] addr_t; // byte address
	typedef logic [3:0] wmask_t; // byte enables of one word

	// one-hot word position inside a line
	typedef logic [LINE_WORDS-1:0] word_sel_t;

	localparam int WDATA_DEPTH = 32; // write data FIFO, words
	localparam int ORDER_DEPTH = 4; // bursts in flight, order FIFO entries

endpackage

/* logic/axi_burst_pkg.sv */
/*
 AXI burst field encodings and response codes used by the bridge
 the burst length follows the cache line size of line_geom_pkg
*/
package axi_burst_pkg;

	typedef logic [1:0] resp_t; // xRESP
	typedef logic [1:0] burst_t; // AxBURST
	typedef logic [2:0] size_t; // AxSIZE
	typedef logic [7:0] len_t; // AxLEN

	// response codes, only OKAY counts as success
	localparam resp_t RESP_OKAY = 2'b00;

	localparam burst_t BURST_INCR = 2'b01; // incrementing burst
	localparam size_t SIZE_WORD = 3'b010; // 4 bytes per beat

	// beats per burst minus one
	localparam len_t BEAT_LEN = len_t'(line_geom_pkg::LINE_WORDS - 1);

endpackage

/* logic/sync_fifo.sv */
/*
 first-word-fall-through FIFO on a register array
 dout shows the head entry whenever empty_n is high, ren pops it
*/
module sync_fifo #(
	parameter int WIDTH = 8, // entry width
	parameter int DEPTH = 4 // number of entries
)(
	input logic aclk,
	input logic aresetn,

	input logic wen,
	input logic [WIDTH-1:0] din,
	output logic full_n,

	input logic ren,
	output logic [WIDTH-1:0] dout,
	output logic empty_n
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH]; // storage, no reset
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // entries held
	logic do_wr;
	logic do_rd;

	// wrap at DEPTH, also for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full_n = (count != CNT_W'(DEPTH));
	assign empty_n = (count != '0);
	assign do_wr = wen & full_n;
	assign do_rd = ren & empty_n;
	assign dout = mem[rd_ptr]; // fall-through head

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_rd)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	// the user gates wen and ren with the flags
	a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
		wen |-> full_n)
		else $error("sync_fifo: write while full");
	a_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn)
		ren |-> empty_n)
		else $error("sync_fifo: read while empty");

endmodule

/* logic/line_read_path.sv */
/*
 read side of the bridge, one AR per line fill
 checks each R beat for an error response or a misplaced rlast
*/
module line_read_path (
	input logic aclk,
	input logic aresetn,

	input logic rd_start, // first word of a read line accepted
	input line_geom_pkg::addr_t rd_addr,
	output logic rd_busy_ar,
	output logic rd_beat_err, // valid with m_axi_rvalid

	output line_geom_pkg::addr_t m_axi_araddr,
	output logic m_axi_arvalid,
	input logic m_axi_arready,

	input logic m_axi_rvalid,
	input logic m_axi_rready,
	input axi_burst_pkg::resp_t m_axi_rresp,
	input logic m_axi_rlast
);

	import line_geom_pkg::*;
	import axi_burst_pkg::*;

	logic ar_pend; // AR request waiting for arready
	addr_t ar_addr_q; // line address of the pending AR
	word_sel_t beat_pos; // one-hot position of the next R beat

	assign m_axi_arvalid = ar_pend;
	assign m_axi_araddr = ar_addr_q;
	assign rd_busy_ar = ar_pend;

	// bad response, or rlast not on the last beat (or missing there)
	assign rd_beat_err = (m_axi_rresp != RESP_OKAY) |
		(m_axi_rlast != beat_pos[LINE_WORDS-1]);

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			ar_pend <= 1'b0;
		else if (rd_start)
			ar_pend <= 1'b1; // arvalid rises next cycle
		else if (m_axi_arready)
			ar_pend <= 1'b0;
	end

	always_ff @(posedge aclk)
	begin
		if (rd_start)
			ar_addr_q <= rd_addr;
	end

	// rotate left by one per R beat
	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			beat_pos <= word_sel_t'(1);
		else if (m_axi_rvalid && m_axi_rready)
			beat_pos <= (beat_pos << 1) | (beat_pos >> (LINE_WORDS - 1));
	end

	// command side must hold off the next fill until the AR is gone
	a_one_ar: assert property (@(posedge aclk) disable iff (!aresetn)
		rd_start |-> !ar_pend)
		else $error("line_read_path: rd_start while AR pending");

endmodule

/* logic/line_write_path.sv */
/*
 write side of the bridge, one AW plus a W burst per line writeback
 write words are queued in a FIFO so they can run ahead of the W channel
*/
module line_write_path (
	input logic aclk,
	input logic aresetn,

	input logic wr_start, // first word of a write line
	input logic wr_push, // any accepted write word
	input line_geom_pkg::addr_t wr_addr,
	input line_geom_pkg::word_t wr_data,
	input line_geom_pkg::wmask_t wr_mask,
	output logic wr_room,
	output logic b_ok,

	output line_geom_pkg::addr_t m_axi_awaddr,
	output logic m_axi_awvalid,
	input logic m_axi_awready,

	output line_geom_pkg::word_t m_axi_wdata,
	output line_geom_pkg::wmask_t m_axi_wstrb,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,

	input logic m_axi_bvalid,
	input logic m_axi_bready,
	input axi_burst_pkg::resp_t m_axi_bresp
);

	import line_geom_pkg::*;
	import axi_burst_pkg::*;

	localparam int PSTR_W = $clog2(WDATA_DEPTH + 1);
	localparam int BPEND_W = $clog2(ORDER_DEPTH + 1);

	logic aw_pend; // AW waiting for awready
	addr_t aw_addr_q;
	word_sel_t push_pos; // position of the next pushed word
	word_sel_t beat_pos; // position of the next W beat
	logic [PSTR_W-1:0] pstr_cnt; // words of announced lines not yet sent on W
	logic [BPEND_W-1:0] b_pend; // bursts whose B is still due
	logic fifo_full_n;
	logic [35:0] fifo_dout; // {data, strobe}
	logic w_fire;
	logic line_fits;

	assign m_axi_awvalid = aw_pend;
	assign m_axi_awaddr = aw_addr_q;

	assign m_axi_wdata = fifo_dout[35:4];
	assign m_axi_wstrb = fifo_dout[3:0];
	assign m_axi_wlast = beat_pos[LINE_WORDS-1]; // every LINE_WORDS-th beat
	assign w_fire = m_axi_wvalid & m_axi_wready;

	// a new line needs room for all of its words
	assign line_fits = (pstr_cnt <= PSTR_W'(WDATA_DEPTH - LINE_WORDS));
	assign wr_room = fifo_full_n & (~push_pos[0] | (~aw_pend & line_fits));

	assign b_ok = m_axi_bvalid & (m_axi_bresp == RESP_OKAY);

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			aw_pend <= 1'b0;
		else if (wr_start)
			aw_pend <= 1'b1;
		else if (m_axi_awready)
			aw_pend <= 1'b0;
	end

	always_ff @(posedge aclk)
	begin
		if (wr_start)
			aw_addr_q <= wr_addr;
	end

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			push_pos <= word_sel_t'(1);
			beat_pos <= word_sel_t'(1);
			pstr_cnt <= '0;
			b_pend <= '0;
		end
		else
		begin
			if (wr_push)
				push_pos <= (push_pos << 1) | (push_pos >> (LINE_WORDS - 1));
			if (w_fire)
				beat_pos <= (beat_pos << 1) | (beat_pos >> (LINE_WORDS - 1));
			// whole line reserved at start, released beat by beat
			pstr_cnt <= pstr_cnt + (wr_start ? PSTR_W'(LINE_WORDS) : '0) -
				(w_fire ? PSTR_W'(1) : '0);
			b_pend <= b_pend + (wr_start ? BPEND_W'(1) : '0) -
				((m_axi_bvalid && m_axi_bready) ? BPEND_W'(1) : '0);
		end
	end

	sync_fifo #(
		.WIDTH(36),
		.DEPTH(WDATA_DEPTH)
	) wdata_fifo (
		.aclk(aclk),
		.aresetn(aresetn),
		.wen(wr_push),
		.din({wr_data, wr_mask}),
		.full_n(fifo_full_n),
		.ren(w_fire),
		.dout(fifo_dout),
		.empty_n(m_axi_wvalid)
	);

	a_w_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid)
		else $error("line_write_path: wvalid dropped before wready");
	a_b_expected: assert property (@(posedge aclk) disable iff (!aresetn)
		m_axi_bvalid && m_axi_bready |-> b_pend != '0)
		else $error("line_write_path: B taken with no write line open");

endmodule

/* logic/burst_order_ctrl.sv */
/*
 command acceptance and in-order response merge for the bridge
 the order FIFO keeps the kind of each line, read or write, oldest first
*/
module burst_order_ctrl (
	input logic aclk,
	input logic aresetn,

	input line_geom_pkg::addr_t icb_cmd_addr,
	input logic icb_cmd_read,
	input line_geom_pkg::word_t icb_cmd_wdata,
	input line_geom_pkg::wmask_t icb_cmd_wmask,
	input logic icb_cmd_valid,
	output logic icb_cmd_ready,

	output line_geom_pkg::word_t icb_rsp_rdata,
	output logic icb_rsp_err,
	output logic icb_rsp_valid,
	input logic icb_rsp_ready,

	output logic rd_start,
	output line_geom_pkg::addr_t rd_addr,
	input logic rd_busy_ar,
	input logic rd_beat_err,

	output logic wr_start,
	output logic wr_push,
	output line_geom_pkg::addr_t wr_addr,
	output line_geom_pkg::word_t wr_data,
	output line_geom_pkg::wmask_t wr_mask,
	input logic wr_room,
	input logic b_ok,

	input line_geom_pkg::word_t m_axi_rdata,
	input logic m_axi_rvalid,
	output logic m_axi_rready,

	input logic m_axi_bvalid,
	output logic m_axi_bready
);

	import line_geom_pkg::*;

	word_sel_t cmd_pos; // word position of the next command
	word_sel_t rsp_pos; // word position of the next response
	logic b_err_q; // B error kept for the rest of the line
	logic cmd_fire;
	logic rsp_fire;
	logic order_full_n;
	logic head_ok; // some burst in flight
	logic head_read; // oldest burst is a read
	logic order_pop;

	// first word opens a burst, it needs an order slot and a free path
	always_comb
	begin
		if (icb_cmd_read)
			icb_cmd_ready = ~cmd_pos[0] | (order_full_n & ~rd_busy_ar);
		else
			icb_cmd_ready = wr_room & (~cmd_pos[0] | order_full_n);
	end

	assign cmd_fire = icb_cmd_valid & icb_cmd_ready;

	assign rd_start = cmd_fire & icb_cmd_read & cmd_pos[0];
	assign rd_addr = icb_cmd_addr;
	assign wr_push = cmd_fire & ~icb_cmd_read;
	assign wr_start = wr_push & cmd_pos[0];
	assign wr_addr = icb_cmd_addr;
	assign wr_data = icb_cmd_wdata;
	assign wr_mask = icb_cmd_wmask;

	// read head passes R straight through, write head waits for B once
	assign icb_rsp_valid = head_ok &
		(head_read ? m_axi_rvalid : (~rsp_pos[0] | m_axi_bvalid));
	assign icb_rsp_rdata = head_read ? m_axi_rdata : '0;
	assign icb_rsp_err = head_read ? rd_beat_err : (rsp_pos[0] ? ~b_ok : b_err_q);

	assign m_axi_rready = head_ok & head_read & icb_rsp_ready;
	assign m_axi_bready = head_ok & ~head_read & rsp_pos[0] & icb_rsp_ready;

	assign rsp_fire = icb_rsp_valid & icb_rsp_ready;
	assign order_pop = rsp_fire & rsp_pos[LINE_WORDS-1]; // last word of the line

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			cmd_pos <= word_sel_t'(1);
			rsp_pos <= word_sel_t'(1);
		end
		else
		begin
			if (cmd_fire)
				cmd_pos <= (cmd_pos << 1) | (cmd_pos >> (LINE_WORDS - 1));
			if (rsp_fire)
				rsp_pos <= (rsp_pos << 1) | (rsp_pos >> (LINE_WORDS - 1));
		end
	end

	always_ff @(posedge aclk)
	begin
		if (m_axi_bvalid && m_axi_bready)
			b_err_q <= ~b_ok;
	end

	sync_fifo #(
		.WIDTH(1),
		.DEPTH(ORDER_DEPTH)
	) order_fifo (
		.aclk(aclk),
		.aresetn(aresetn),
		.wen(cmd_fire & cmd_pos[0]),
		.din(icb_cmd_read),
		.full_n(order_full_n),
		.ren(order_pop),
		.dout(head_read),
		.empty_n(head_ok)
	);

endmodule

/* logic/dcache_mem_icb_to_axi.sv */
/*
 data cache next-level memory bridge, ICB word commands to AXI line bursts
 each group of LINE_WORDS commands becomes one INCR burst of 4-byte beats
*/
module dcache_mem_icb_to_axi (
	input logic aclk,
	input logic aresetn,

	input line_geom_pkg::addr_t icb_cmd_addr,
	input logic icb_cmd_read,
	input line_geom_pkg::word_t icb_cmd_wdata,
	input line_geom_pkg::wmask_t icb_cmd_wmask,
	input logic icb_cmd_valid,
	output logic icb_cmd_ready,

	output line_geom_pkg::word_t icb_rsp_rdata,
	output logic icb_rsp_err,
	output logic icb_rsp_valid,
	input logic icb_rsp_ready,

	output line_geom_pkg::addr_t m_axi_araddr,
	output axi_burst_pkg::burst_t m_axi_arburst,
	output axi_burst_pkg::len_t m_axi_arlen,
	output axi_burst_pkg::size_t m_axi_arsize,
	output logic m_axi_arvalid,
	input logic m_axi_arready,

	input line_geom_pkg::word_t m_axi_rdata,
	input axi_burst_pkg::resp_t m_axi_rresp,
	input logic m_axi_rlast,
	input logic m_axi_rvalid,
	output logic m_axi_rready,

	output line_geom_pkg::addr_t m_axi_awaddr,
	output axi_burst_pkg::burst_t m_axi_awburst,
	output axi_burst_pkg::len_t m_axi_awlen,
	output axi_burst_pkg::size_t m_axi_awsize,
	output logic m_axi_awvalid,
	input logic m_axi_awready,

	output line_geom_pkg::word_t m_axi_wdata,
	output line_geom_pkg::wmask_t m_axi_wstrb,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,

	input axi_burst_pkg::resp_t m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready
);

	import line_geom_pkg::*;
	import axi_burst_pkg::*;

	logic rd_start;
	addr_t rd_addr;
	logic rd_busy_ar;
	logic rd_beat_err;
	logic wr_start;
	logic wr_push;
	addr_t wr_addr;
	word_t wr_data;
	wmask_t wr_mask;
	logic wr_room;
	logic b_ok;

	// fixed burst shape, full lines only
	assign m_axi_arlen = BEAT_LEN;
	assign m_axi_arsize = SIZE_WORD;
	assign m_axi_arburst = BURST_INCR;
	assign m_axi_awlen = BEAT_LEN;
	assign m_axi_awsize = SIZE_WORD;
	assign m_axi_awburst = BURST_INCR;

	burst_order_ctrl u_order (
		.aclk(aclk), .aresetn(aresetn),
		.icb_cmd_addr(icb_cmd_addr), .icb_cmd_read(icb_cmd_read),
		.icb_cmd_wdata(icb_cmd_wdata), .icb_cmd_wmask(icb_cmd_wmask),
		.icb_cmd_valid(icb_cmd_valid), .icb_cmd_ready(icb_cmd_ready),
		.icb_rsp_rdata(icb_rsp_rdata), .icb_rsp_err(icb_rsp_err),
		.icb_rsp_valid(icb_rsp_valid), .icb_rsp_ready(icb_rsp_ready),
		.rd_start(rd_start), .rd_addr(rd_addr),
		.rd_busy_ar(rd_busy_ar), .rd_beat_err(rd_beat_err),
		.wr_start(wr_start), .wr_push(wr_push), .wr_addr(wr_addr),
		.wr_data(wr_data), .wr_mask(wr_mask), .wr_room(wr_room), .b_ok(b_ok),
		.m_axi_rdata(m_axi_rdata), .m_axi_rvalid(m_axi_rvalid),
		.m_axi_rready(m_axi_rready),
		.m_axi_bvalid(m_axi_bvalid), .m_axi_bready(m_axi_bready)
	);

	line_read_path u_read (
		.aclk(aclk), .aresetn(aresetn),
		.rd_start(rd_start), .rd_addr(rd_addr),
		.rd_busy_ar(rd_busy_ar), .rd_beat_err(rd_beat_err),
		.m_axi_araddr(m_axi_araddr), .m_axi_arvalid(m_axi_arvalid),
		.m_axi_arready(m_axi_arready),
		.m_axi_rvalid(m_axi_rvalid), .m_axi_rready(m_axi_rready),
		.m_axi_rresp(m_axi_rresp), .m_axi_rlast(m_axi_rlast)
	);

	line_write_path u_write (
		.aclk(aclk), .aresetn(aresetn),
		.wr_start(wr_start), .wr_push(wr_push), .wr_addr(wr_addr),
		.wr_data(wr_data), .wr_mask(wr_mask), .wr_room(wr_room), .b_ok(b_ok),
		.m_axi_awaddr(m_axi_awaddr), .m_axi_awvalid(m_axi_awvalid),
		.m_axi_awready(m_axi_awready),
		.m_axi_wdata(m_axi_wdata), .m_axi_wstrb(m_axi_wstrb),
		.m_axi_wlast(m_axi_wlast), .m_axi_wvalid(m_axi_wvalid),
		.m_axi_wready(m_axi_wready),
		.m_axi_bvalid(m_axi_bvalid), .m_axi_bready(m_axi_bready),
		.m_axi_bresp(m_axi_bresp)
	);

endmodule

/* sim/tb_axi_mem_model.sv */
/*
 AXI slave memory for the bridge testbench serving one burst at a time per direction
 adds random ready and valid gaps and answers SLVERR from line 32'h0000_F000 up
*/
module tb_axi_mem_model (
	input logic aclk,
	input logic aresetn,
	input line_geom_pkg::addr_t araddr,
	input axi_burst_pkg::burst_t arburst,
	input axi_burst_pkg::len_t arlen,
	input axi_burst_pkg::size_t arsize,
	input logic arvalid,
	output logic arready,
	output line_geom_pkg::word_t rdata,
	output axi_burst_pkg::resp_t rresp,
	output logic rlast,
	output logic rvalid,
	input logic rready,
	input line_geom_pkg::addr_t awaddr,
	input axi_burst_pkg::burst_t awburst,
	input axi_burst_pkg::len_t awlen,
	input axi_burst_pkg::size_t awsize,
	input logic awvalid,
	output logic awready,
	input line_geom_pkg::word_t wdata,
	input line_geom_pkg::wmask_t wstrb,
	input logic wlast,
	input logic wvalid,
	output logic wready,
	output axi_burst_pkg::resp_t bresp,
	output logic bvalid,
	input logic bready,
	output int proto_errs // burst field and wlast errors
);
	timeunit 1ns;
	timeprecision 1ps;
	import line_geom_pkg::*;
	import axi_burst_pkg::*;

	localparam resp_t RESP_SLVERR = 2'b10;
	localparam addr_t ERR_BASE = 32'h0000_F000;

	word_t mem [0:16383]; // 64 KiB preloaded by the testbench
	addr_t rd_q[$]; // accepted AR addresses in arrival order
	addr_t wr_q[$]; // accepted AW addresses
	resp_t b_q[$]; // B responses still to send
	integer seed = 32'h193ed487;
	int r_beat;
	int w_beat;
	int k;
	logic r_hs;
	logic b_hs;
	addr_t a;

	task automatic check_burst(input string ch, input burst_t b, input len_t l, input size_t s);
		// a line is LINE_WORDS incrementing beats of 4 bytes
		if (l != len_t'(LINE_WORDS - 1) || b != 2'b01 || s != 3'd2)
		begin
			$display("error at %0t: %s burst len %0d type %0d size %0d", $time, ch, l, b, s);
			proto_errs++;
		end
	endtask

	initial
	begin
		{arready, awready, wready, rvalid, rlast, bvalid} = '0;
		rdata = '0;
		rresp = RESP_OKAY;
		bresp = RESP_OKAY;
		proto_errs = 0;
	end

	always @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			{arready, awready, wready, rvalid, rlast, bvalid} = '0;
			rd_q.delete();
			wr_q.delete();
			b_q.delete();
			r_beat = 0;
			w_beat = 0;
		end
		else
		begin
			r_hs = rvalid & rready; // handshakes seen at this edge
			b_hs = bvalid & bready;
			if (arvalid && arready)
			begin
				check_burst("AR", arburst, arlen, arsize);
				rd_q.push_back(araddr);
			end
			if (awvalid && awready)
			begin
				check_burst("AW", awburst, awlen, awsize);
				wr_q.push_back(awaddr);
			end
			if (r_hs)
			begin
				if (rlast)
				begin
					rd_q.delete(0);
					r_beat = 0;
				end
				else
					r_beat++;
			end
			if (wvalid && wready)
			begin
				if (wlast != (w_beat == LINE_WORDS - 1))
				begin
					$display("error at %0t: wlast %0b on beat %0d", $time, wlast, w_beat);
					proto_errs++;
				end
				a = wr_q[0] + 4 * w_beat;
				if (wr_q[0] < ERR_BASE) // error lines leave memory alone
					for (k = 0; k < 4; k++)
						if (wstrb[k])
							mem[a[15:2]][8*k +: 8] = wdata[8*k +: 8];
				if (w_beat == LINE_WORDS - 1)
				begin
					b_q.push_back((wr_q[0] < ERR_BASE) ? RESP_OKAY : RESP_SLVERR);
					wr_q.delete(0);
					w_beat = 0;
				end
				else
					w_beat++;
			end
			if (b_hs)
				b_q.delete(0);
			#2;
			arready = ($random(seed) & 3) != 0;
			awready = ($random(seed) & 3) != 0;
			wready = (wr_q.size() != 0) && (($random(seed) & 3) != 0); // W waits for its AW
			if (!rvalid || r_hs)
			begin
				rvalid = (rd_q.size() != 0) && (($random(seed) & 3) != 0);
				if (rvalid)
				begin
					a = rd_q[0] + 4 * r_beat;
					rresp = (rd_q[0] < ERR_BASE) ? RESP_OKAY : RESP_SLVERR;
					rdata = (rd_q[0] < ERR_BASE) ? mem[a[15:2]] : '0;
					rlast = (r_beat == LINE_WORDS - 1);
				end
			end
			if (!bvalid || b_hs)
			begin
				bvalid = (b_q.size() != 0) && (($random(seed) & 3) != 0);
				bresp = bvalid ? b_q[0] : RESP_OKAY;
			end
		end
	end

endmodule

/* sim/tb_dcache_mem_icb_to_axi.sv */
/*
 testbench for the ICB to AXI line bridge
 drives line fills and writebacks and predicts every response word in command order
*/
module tb_dcache_mem_icb_to_axi;
	timeunit 1ns;
	timeprecision 1ps;
	import line_geom_pkg::*;
	import axi_burst_pkg::*;

	localparam int CYCLE_LIMIT = 20000; // tests need a few thousand at most
	localparam addr_t ERR_BASE = 32'h0000_F000;

	logic aclk;
	logic aresetn;
	addr_t icb_cmd_addr;
	logic icb_cmd_read;
	word_t icb_cmd_wdata;
	wmask_t icb_cmd_wmask;
	logic icb_cmd_valid, icb_cmd_ready;
	word_t icb_rsp_rdata;
	logic icb_rsp_err, icb_rsp_valid, icb_rsp_ready;
	addr_t m_axi_araddr, m_axi_awaddr;
	burst_t m_axi_arburst, m_axi_awburst;
	len_t m_axi_arlen, m_axi_awlen;
	size_t m_axi_arsize, m_axi_awsize;
	logic m_axi_arvalid, m_axi_arready, m_axi_awvalid, m_axi_awready;
	word_t m_axi_rdata, m_axi_wdata;
	resp_t m_axi_rresp, m_axi_bresp;
	logic m_axi_rlast, m_axi_rvalid, m_axi_rready;
	wmask_t m_axi_wstrb;
	logic m_axi_wlast, m_axi_wvalid, m_axi_wready;
	logic m_axi_bvalid, m_axi_bready;
	int proto_errs;

	word_t shadow [0:16383]; // expected memory contents
	logic [33:0] exp_q[$]; // {is_read, err, rdata} per command word
	logic [33:0] exp;
	integer seed = 32'h193ed487;
	logic rsp_gaps; // random icb_rsp_ready when set
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int last_errors = 0;

	dcache_mem_icb_to_axi UUT (.*);

	tb_axi_mem_model mem_model (
		.aclk(aclk), .aresetn(aresetn),
		.araddr(m_axi_araddr), .arburst(m_axi_arburst), .arlen(m_axi_arlen),
		.arsize(m_axi_arsize), .arvalid(m_axi_arvalid), .arready(m_axi_arready),
		.rdata(m_axi_rdata), .rresp(m_axi_rresp), .rlast(m_axi_rlast),
		.rvalid(m_axi_rvalid), .rready(m_axi_rready),
		.awaddr(m_axi_awaddr), .awburst(m_axi_awburst), .awlen(m_axi_awlen),
		.awsize(m_axi_awsize), .awvalid(m_axi_awvalid), .awready(m_axi_awready),
		.wdata(m_axi_wdata), .wstrb(m_axi_wstrb), .wlast(m_axi_wlast),
		.wvalid(m_axi_wvalid), .wready(m_axi_wready),
		.bresp(m_axi_bresp), .bvalid(m_axi_bvalid), .bready(m_axi_bready),
		.proto_errs(proto_errs)
	);

	function automatic word_t fill_word(input int idx);
		return (idx * 32'h9E37_79B1) ^ 32'h5A0F_C3E1; // odd multiplier keeps every index distinct
	endfunction

	// reference model called once per command word in command order
	function automatic logic [33:0] predict(input addr_t addr, input logic rd,
		input word_t wdata, input wmask_t wmask);
		logic [13:0] idx;
		idx = addr[15:2];
		if (addr >= ERR_BASE)
			return {rd, 1'b1, 32'h0}; // SLVERR line returns no data and writes nothing
		if (rd)
			return {1'b1, 1'b0, shadow[idx]};
		for (int b = 0; b < 4; b++)
			if (wmask[b])
				shadow[idx][8*b +: 8] = wdata[8*b +: 8];
		return {1'b0, 1'b0, 32'h0};
	endfunction

	task automatic send_line(input addr_t base, input logic rd, input logic rand_mask);
		for (int i = 0; i < LINE_WORDS; i++)
		begin
			icb_cmd_addr = base + 4 * i;
			icb_cmd_read = rd;
			icb_cmd_wdata = $random(seed);
			icb_cmd_wmask = rand_mask ? wmask_t'($random(seed)) : 4'hF;
			icb_cmd_valid = 1'b1;
			exp_q.push_back(predict(icb_cmd_addr, rd, icb_cmd_wdata, icb_cmd_wmask));
			@(posedge aclk);
			while (!icb_cmd_ready)
				@(posedge aclk);
			#2;
		end
		icb_cmd_valid = 1'b0;
	endtask

	task automatic wait_responses();
		while (exp_q.size() != 0)
			@(posedge aclk);
		#2; // next drive stays clear of the edge
	endtask

	task automatic report_test(input string name);
		wait_responses();
		$display("%s: finished, %0d errors", name, errors - last_errors);
		last_errors = errors;
	endtask

	initial
	begin
		aclk = 1'b0;
		forever #10 aclk = ~aclk;
	end

	always @(posedge aclk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: run stopped at cycle %0d with responses missing", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	always @(posedge aclk)
	begin
		#2;
		icb_rsp_ready = !rsp_gaps || (($random(seed) & 1) != 0);
	end

	// compare each accepted response with the oldest prediction
	always @(posedge aclk)
	begin
		if (aresetn && icb_rsp_valid && icb_rsp_ready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("response at %0t arrived with no command outstanding", $time);
				errors++;
			end
			else
			begin
				exp = exp_q.pop_front();
				checks++;
				if (icb_rsp_err !== exp[32])
				begin
					$display("error at %0t: rsp err %0b, expected %0b", $time, icb_rsp_err, exp[32]);
					errors++;
				end
				if (exp[33] && icb_rsp_rdata !== exp[31:0])
				begin
					$display("error at %0t: rdata %h, expected %h", $time, icb_rsp_rdata, exp[31:0]);
					errors++;
				end
			end
		end
	end

	initial
	begin
		aresetn = 1'b0;
		icb_cmd_addr = '0;
		icb_cmd_read = 1'b0;
		icb_cmd_wdata = '0;
		icb_cmd_wmask = '0;
		icb_cmd_valid = 1'b0;
		icb_rsp_ready = 1'b1;
		rsp_gaps = 1'b0;
		for (int i = 0; i < 16384; i++)
		begin
			shadow[i] = fill_word(i);
			mem_model.mem[i] = shadow[i];
		end
		repeat (8) @(posedge aclk);
		#2;
		aresetn = 1'b1;

		send_line(32'h0000_1000, 1'b1, 1'b0);
		report_test("line fill");
		send_line(32'h0000_2000, 1'b0, 1'b0);
		wait_responses(); // writeback lands before the fill is issued
		send_line(32'h0000_2000, 1'b1, 1'b0);
		report_test("writeback then fill");
		send_line(32'h0000_3000, 1'b0, 1'b1);
		wait_responses();
		send_line(32'h0000_3000, 1'b1, 1'b0);
		report_test("partial byte masks");
		send_line(32'h0000_F000, 1'b1, 1'b0);
		send_line(32'h0000_F020, 1'b0, 1'b0);
		send_line(32'h0000_F020, 1'b1, 1'b0);
		report_test("error region");

		rsp_gaps = 1'b1;
		for (int n = 0; n < 12; n++)
			if ($random(seed) & 1)
				send_line(32'h0000_1000 + 32 * (n % 4), 1'b1, 1'b0); // lines never written
			else
				send_line(32'h0000_4000 + 32 * n, 1'b0, 1'b1);
		report_test("mixed lines with gaps");
		rsp_gaps = 1'b0;

		$display("burst field checks: finished, %0d errors", proto_errs);
		$display("%0d response words checked, %0d errors", checks, errors + proto_errs);
		if (errors + proto_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* flist.f */
logic/line_geom_pkg.sv
logic/axi_burst_pkg.sv
logic/sync_fifo.sv
logic/line_read_path.sv
logic/line_write_path.sv
logic/burst_order_ctrl.sv
logic/dcache_mem_icb_to_axi.sv
sim/tb_axi_mem_model.sv
sim/tb_dcache_mem_icb_to_axi.sv
